// ==== arrayHeap.sv ====
//----------------------------------------------------------------------
// Array heap top level
// Allocator and size table feed the access control and the store
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arrayHeap (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire                    request,
  input  wire heapPkg::heapRequest command,
  output logic                   responseValid,
  output heapPkg::heapResponse   response
);
  import heapPkg::*;

  arrayState   state;
  arrayNumber  grantedArray;
  logic        grantOk;
  sizeStatus   sizes;
  heapData     readData;
  logic        allocate, releaseArray, clearAll;
  sizeOp       op;
  arrayNumber  target;
  elementIndex extendIndex;
  logic        writeEnable;
  elementIndex storeIndex;
  heapData     writeData;

  heapAllocator allocator (
    .clock, .resetN, .array(command.array), .allocate, .releaseArray,
    .clearAll, .state, .grantedArray, .grantOk
  );

  arraySizeTable sizeTable (
    .clock, .resetN, .array(command.array), .index(command.index),
    .op, .target, .extendIndex, .status(sizes)
  );

  elementStore store (
    .clock, .array(command.array), .index(storeIndex), .writeEnable,
    .writeData, .readData
  );

  heapAccessControl control (
    .clock, .resetN, .request, .command, .state, .grantedArray, .grantOk,
    .sizes, .readData, .allocate, .releaseArray, .clearAll, .op, .target,
    .extendIndex, .writeEnable, .storeIndex, .writeData, .responseValid,
    .response
  );

endmodule

`default_nettype wire

// ==== arrayHeapTb.sv ====
//----------------------------------------------------------------------
// Array heap testbench
// Applies a command table and checks each one-cycle response
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arrayHeapTb;
  import heapPkg::*;

  localparam int ClockPeriod = 10;                   // ns
  localparam int RowCount    = 36;                   // Commands in the table

  typedef struct packed {
    heapRequest command;
    heapData    expData;                             // Expected response data
    heapError   expError;                            // Expected status
  } testRow;

  logic        clock;
  logic        resetN;
  logic        request;
  heapRequest  command;
  logic        responseValid;
  heapResponse response;

  testRow rows [RowCount];
  int     rowFill      = 0;                          // Next free table slot
  int     dataErrors   = 0;
  int     statusErrors = 0;
  int     flowErrors   = 0;                          // Pulse and table problems

  arrayHeap dut (
    .clock, .resetN, .request, .command, .responseValid, .response
  );

  initial begin
    clock = 1'b0;
    forever #(ClockPeriod / 2) clock = ~clock;
  end

  //--------------------------------------------------------------------
  // Table construction and compare tasks
  //--------------------------------------------------------------------
  task automatic addRow(input heapAction action, input arrayNumber array,
                        input elementIndex index, input heapData data,
                        input heapData expData, input heapError expError);
    testRow entry;
    entry.command.action = action;
    entry.command.array  = array;
    entry.command.index  = index;
    entry.command.data   = data;
    entry.expData        = expData;
    entry.expError       = expError;
    rows[rowFill]        = entry;
    rowFill++;
  endtask

  task automatic loadRows();
    addRow(actAlloc, 0, 0, 0,    0,    errNone);     // Fresh arrays in order
    addRow(actAlloc, 0, 0, 0,    1,    errNone);
    addRow(actAlloc, 0, 0, 0,    2,    errNone);
    addRow(actAlloc, 0, 0, 0,    3,    errNone);
    addRow(actAlloc, 0, 0, 0,    0,    errOutOfMemory); // All four taken
    addRow(actWrite, 0, 0, 11,   11,   errNone);
    addRow(actWrite, 0, 1, 22,   22,   errNone);
    addRow(actSize,  0, 0, 0,    2,    errNone);     // Writes extended size
    addRow(actRead,  0, 3, 0,    0,    errOutOfBounds);
    addRow(actRead,  0, 1, 0,    22,   errNone);
    addRow(actWrite, 1, 2, 7,    7,    errNone);     // Array 1 grows to 3
    addRow(actFree,  1, 0, 0,    0,    errNone);
    addRow(actFree,  1, 0, 0,    0,    errFreed);    // Double free
    addRow(actAlloc, 0, 0, 0,    1,    errNone);     // Reuses array 1
    addRow(actSize,  1, 0, 0,    0,    errNone);
    addRow(actPush,  2, 0, 100,  0,    errNone);
    addRow(actPush,  2, 0, 200,  0,    errNone);
    addRow(actPush,  2, 0, 300,  0,    errNone);
    addRow(actPush,  2, 0, 400,  0,    errNone);
    addRow(actPush,  2, 0, 500,  0,    errFull);
    addRow(actPop,   2, 0, 0,    400,  errNone);     // Last in first out
    addRow(actPop,   2, 0, 0,    300,  errNone);
    addRow(actPop,   2, 0, 0,    200,  errNone);
    addRow(actPop,   2, 0, 0,    100,  errNone);
    addRow(actPop,   2, 0, 0,    0,    errEmpty);
    addRow(actWrite, 3, 0, 4095, 4095, errNone);
    addRow(actAdd,   3, 0, 5,    4,    errNone);     // Wraps at 12 bits
    addRow(actRead,  3, 0, 0,    4,    errNone);
    addRow(actClear, 0, 0, 0,    0,    errNone);
    addRow(actAdd,   3, 0, 5,    0,    errUnallocated);
    addRow(actAlloc, 0, 0, 0,    0,    errNone);     // Counter restarted
    addRow(actAlloc, 0, 0, 0,    1,    errNone);
    addRow(actFree,  0, 0, 0,    0,    errNone);
    addRow(actFree,  1, 0, 0,    0,    errNone);
    addRow(actAlloc, 0, 0, 0,    1,    errNone);     // Last freed comes back first
    addRow(actAlloc, 0, 0, 0,    0,    errNone);
  endtask

  task automatic checkData(input int row, input heapData actual, input heapData expected);
    if (actual !== expected) begin
      dataErrors++;
      $display("mismatch at %0t ns: row %0d data %0d, expected %0d",
               $time, row, actual, expected);
    end
  endtask

  task automatic checkError(input int row, input heapError actual, input heapError expected);
    if (actual !== expected) begin
      statusErrors++;
      $display("mismatch at %0t ns: row %0d status %s, expected %s",
               $time, row, actual.name(), expected.name());
    end
  endtask

  task automatic checkPulse(input int row);
    if (responseValid !== 1'b1) begin
      flowErrors++;
      $display("Row %0d got no response pulse one cycle after its command", row);
    end
  endtask

  //--------------------------------------------------------------------
  // Stimulus, one row per cycle
  //--------------------------------------------------------------------
  initial begin
    request = 1'b0;
    command = '0;
    resetN  = 1'b0;                                  // Held for two cycles
    loadRows();
    if (rowFill != RowCount) begin
      flowErrors++;
      $display("Command table holds %0d rows instead of %0d", rowFill, RowCount);
    end
    repeat (2) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    if (responseValid !== 1'b0) begin
      flowErrors++;
      $display("Response pulse present right after reset");
    end
    for (int i = 0; i < RowCount; i++) begin
      request = 1'b1;
      command = rows[i].command;
      @(negedge clock);                              // Response stable here
      checkPulse(i);
      checkData(i, response.data, rows[i].expData);
      checkError(i, response.error, rows[i].expError);
    end
    request = 1'b0;
    command = '0;
    @(negedge clock);
    if (responseValid !== 1'b0) begin
      flowErrors++;
      $display("Response pulse seen without a command");
    end
    $display("Errors: data %0d, status %0d, flow %0d", dataErrors, statusErrors, flowErrors);
    if (dataErrors + statusErrors + flowErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #((RowCount + 10) * ClockPeriod);
    $display("Timeout, the run did not finish within %0d ns", (RowCount + 10) * ClockPeriod);
    $display("Errors: data %0d, status %0d, flow %0d", dataErrors, statusErrors, flowErrors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== arraySizeTable.sv ====
//----------------------------------------------------------------------
// Array size table
// One size per array, status for the addressed array
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module arraySizeTable (
  input  wire                     clock,
  input  wire                     resetN,
  input  wire heapPkg::arrayNumber  array,           // Addressed array
  input  wire heapPkg::elementIndex index,           // Command index
  input  wire heapPkg::sizeOp       op,              // Size change to commit
  input  wire heapPkg::arrayNumber  target,          // Array to change
  input  wire heapPkg::elementIndex extendIndex,     // Written position
  output heapPkg::sizeStatus      status
);
  import heapPkg::*;

  arraySize sizes [ArrayCount];
  arraySize extendSize;                              // Size implied by a write

  assign extendSize = arraySize'(extendIndex) + 1'b1;

  always_comb begin
    status.size     = sizes[array];
    status.inBounds = arraySize'(index) < sizes[array];
    status.full     = sizes[array] == ArrayLength;
    status.empty    = sizes[array] == '0;
    status.topIndex = elementIndex'(sizes[array] - 1'b1); // Valid when not empty
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < ArrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      case (op)
        sizeGrow:   sizes[target] <= sizes[target] + 1'b1;
        sizeShrink: sizes[target] <= sizes[target] - 1'b1;
        sizeZero:   sizes[target] <= '0;
        sizeExtend: begin
          if (extendSize > sizes[target]) begin
            sizes[target] <= extendSize;             // Only ever grows
          end
        end
        default: ;
      endcase
    end
  end

  // Access control must block grow on a full array
  assert property (@(posedge clock) disable iff (!resetN)
    op == sizeGrow |=> sizes[$past(target)] <= ArrayLength);

endmodule

`default_nettype wire

// ==== elementStore.sv ====
//----------------------------------------------------------------------
// Element store
// Array by index memory, combinational read, clocked write
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module elementStore (
  input  wire                     clock,
  input  wire heapPkg::arrayNumber  array,
  input  wire heapPkg::elementIndex index,
  input  wire                     writeEnable,
  input  wire heapPkg::heapData     writeData,
  output heapPkg::heapData        readData
);
  import heapPkg::*;

  heapData memory [ArrayCount][ArrayLength];         // Fixed block per array

  assign readData = memory[array][index];            // Same cycle read

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      memory[array][index] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
heapPkg.sv
heapAllocator.sv
arraySizeTable.sv
elementStore.sv
heapAccessControl.sv
arrayHeap.sv
arrayHeapTb.sv

// ==== heapAccessControl.sv ====
//----------------------------------------------------------------------
// Heap access control
// Picks the error, commits updates and registers the response
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module heapAccessControl (
  input  wire                       clock,
  input  wire                       resetN,
  input  wire                       request,         // Command strobe
  input  wire heapPkg::heapRequest    command,
  input  wire heapPkg::arrayState     state,         // From allocator
  input  wire heapPkg::arrayNumber    grantedArray,
  input  wire                       grantOk,
  input  wire heapPkg::sizeStatus     sizes,         // From size table
  input  wire heapPkg::heapData       readData,      // From store
  output logic                      allocate,
  output logic                      releaseArray,
  output logic                      clearAll,
  output heapPkg::sizeOp            op,
  output heapPkg::arrayNumber       target,
  output heapPkg::elementIndex      extendIndex,
  output logic                      writeEnable,
  output heapPkg::elementIndex      storeIndex,
  output heapPkg::heapData          writeData,
  output logic                      responseValid,   // One cycle after request
  output heapPkg::heapResponse      response
);
  import heapPkg::*;

  heapError error;
  heapData  sum;                                     // Add result, wraps
  heapData  resultData;
  logic     commit;                                  // Request with no error
  logic     needsArray;

  assign needsArray = command.action inside {actFree, actWrite, actRead,
                                             actSize, actPush, actPop, actAdd};
  assign sum        = readData + command.data;

  //--------------------------------------------------------------------
  // Error choice, first match wins
  //--------------------------------------------------------------------
  always_comb begin
    error = errNone;
    if (needsArray && state == stateUnallocated) begin
      error = errUnallocated;
    end else if (needsArray && state == stateFreed) begin
      error = errFreed;
    end else if (command.action inside {actRead, actAdd} && !sizes.inBounds) begin
      error = errOutOfBounds;
    end else if (command.action == actPush && sizes.full) begin
      error = errFull;
    end else if (command.action == actPop && sizes.empty) begin
      error = errEmpty;
    end else if (command.action == actAlloc && !grantOk) begin
      error = errOutOfMemory;
    end
  end

  assign commit = request && error == errNone;

  // Updates to allocator, size table and store
  always_comb begin
    allocate     = commit && command.action == actAlloc;
    releaseArray = commit && command.action == actFree;
    clearAll     = commit && command.action == actClear;
    target       = (command.action == actAlloc) ? grantedArray : command.array;
    extendIndex  = command.index;
    op           = sizeHold;
    if (commit) begin
      case (command.action)
        actAlloc: op = sizeZero;                     // Reused arrays start empty
        actWrite: op = sizeExtend;
        actPush:  op = sizeGrow;
        actPop:   op = sizeShrink;
        default:  op = sizeHold;
      endcase
    end
    case (command.action)
      actPush: storeIndex = sizes.size[IndexBits-1:0]; // Next free slot
      actPop:  storeIndex = sizes.topIndex;
      default: storeIndex = command.index;
    endcase
    writeEnable = commit && command.action inside {actWrite, actPush, actAdd};
    writeData   = (command.action == actAdd) ? sum : command.data;
  end

  always_comb begin
    case (command.action)
      actAlloc:         resultData = heapData'(grantedArray);
      actWrite:         resultData = command.data;
      actRead, actPop:  resultData = readData;
      actSize:          resultData = heapData'(sizes.size);
      actAdd:           resultData = sum;            // New value
      default:          resultData = '0;             // Free, clear, push
    endcase
    if (error != errNone) begin
      resultData = '0;
    end
  end

  //--------------------------------------------------------------------
  // Response register
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      responseValid <= 1'b0;
    end else begin
      responseValid <= request;
    end
  end

  always_ff @(posedge clock) begin
    if (request) begin
      response.data  <= resultData;
      response.error <= error;
    end
  end

  // Strobe only with a defined action
  assert property (@(posedge clock) disable iff (!resetN)
    request |-> command.action <= actAdd);

endmodule

`default_nettype wire

// ==== heapAllocator.sv ====
//----------------------------------------------------------------------
// Heap allocator
// Live flags, fresh array counter and a stack of freed arrays
//----------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module heapAllocator (
  input  wire                    clock,
  input  wire                    resetN,
  input  wire heapPkg::arrayNumber array,            // Array under query
  input  wire                    allocate,           // Take the granted array
  input  wire                    releaseArray,       // Free the queried array
  input  wire                    clearAll,
  output heapPkg::arrayState     state,
  output heapPkg::arrayNumber    grantedArray,
  output logic                   grantOk
);
  import heapPkg::*;

  logic [ArrayCount-1:0] live;                       // One flag per array
  logic [ArrayBits:0]    usedCount;                  // Arrays ever handed out
  logic [ArrayBits:0]    freeTop;                    // Free stack depth
  arrayNumber            freeStack [ArrayCount];     // Last freed on top
  logic                  haveFreed;

  assign haveFreed = freeTop != '0;

  // Reuse the most recently freed array before a fresh one
  always_comb begin
    grantedArray = usedCount[ArrayBits-1:0];
    if (haveFreed) begin
      grantedArray = freeStack[freeTop[ArrayBits-1:0] - 1'b1];
    end
    grantOk = haveFreed || (usedCount < ArrayCount);
  end

  always_comb begin
    if (live[array]) begin
      state = stateLive;
    end else if ({1'b0, array} < usedCount) begin
      state = stateFreed;                            // Handed out before, now idle
    end else begin
      state = stateUnallocated;
    end
  end

  //--------------------------------------------------------------------
  // Control state
  //--------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      live      <= '0;
      usedCount <= '0;
      freeTop   <= '0;
    end else if (clearAll) begin
      live      <= '0;
      usedCount <= '0;
      freeTop   <= '0;
    end else if (allocate) begin
      live[grantedArray] <= 1'b1;
      if (haveFreed) begin
        freeTop <= freeTop - 1'b1;                   // Pop free stack
      end else begin
        usedCount <= usedCount + 1'b1;               // Fresh array
      end
    end else if (releaseArray) begin
      live[array] <= 1'b0;
      freeTop     <= freeTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (releaseArray && !clearAll) begin
      freeStack[freeTop[ArrayBits-1:0]] <= array;    // Push freed array
    end
  end

  // Only live arrays get freed, so the stack can never outgrow the heap
  assert property (@(posedge clock) disable iff (!resetN)
    releaseArray |-> freeTop < ArrayCount);

endmodule

`default_nettype wire

// ==== heapPkg.sv ====
//----------------------------------------------------------------------
// Array heap shared definitions
// Widths, counts, command and status codes, request and response
//----------------------------------------------------------------------
`default_nettype none

package heapPkg;

  localparam int ArrayBits   = 2;                    // Bits in an array number
  localparam int IndexBits   = 2;                    // Bits in an element index
  localparam int DataBits    = 12;                   // Element width
  localparam int ArrayCount  = 4;                    // Arrays in the heap
  localparam int ArrayLength = 4;                    // Max elements per array

  typedef logic [ArrayBits-1:0] arrayNumber;         // Which array
  typedef logic [IndexBits-1:0] elementIndex;        // Position inside an array
  typedef logic [IndexBits:0]   arraySize;           // Element count 0 to 4
  typedef logic [DataBits-1:0]  heapData;            // Element value

  typedef enum logic [3:0] {
    actClear,                                        // Whole heap clear
    actAlloc,                                        // Grant a new array
    actFree,                                         // Return an array
    actWrite,                                        // Write, extends size
    actRead,                                         // Read an element
    actSize,                                         // Size query
    actPush,                                         // Append at top
    actPop,                                          // Remove from top
    actAdd                                           // Add, return new value
  } heapAction;

  typedef enum logic [2:0] {
    errNone,
    errUnallocated,
    errFreed,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapError;

  typedef enum logic [1:0] {
    stateUnallocated,                                // Never handed out
    stateLive,                                       // Handed out, in use
    stateFreed                                       // Handed out then freed
  } arrayState;

  typedef enum logic [2:0] {
    sizeHold,
    sizeGrow,                                        // Plus one
    sizeShrink,                                      // Minus one
    sizeExtend,                                      // Up to extend index plus one
    sizeZero                                         // Empty the target
  } sizeOp;

  typedef struct packed {
    heapAction   action;
    arrayNumber  array;
    elementIndex index;
    heapData     data;
  } heapRequest;

  typedef struct packed {
    heapData  data;                                  // Zero on any error
    heapError error;
  } heapResponse;

  typedef struct packed {
    arraySize    size;                               // Current size of addressed array
    logic        inBounds;                           // Command index below size
    logic        full;
    logic        empty;
    elementIndex topIndex;                           // Last element position
  } sizeStatus;

endpackage

`default_nettype wire
